//--- source/lsu_pkg.sv
package lsu_pkg;

    // access size, encoded as log2 of the byte count so it maps onto AxSIZE
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // core-local timer window
    // mtime low word at the base, high word at base + 4
    localparam logic [31:0] CLINT_BASE = 32'h0200_0048;
    localparam logic [31:0] CLINT_LAST = 32'h0200_004F;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // fixed AXI fields for single-beat transfers
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_ID         = 4'd0;

endpackage

//--- source/mem_bus_if.sv
interface mem_bus_if;
    import lsu_pkg::*;

    // request side
    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    size_t       size;

    // reply side, valid in the single ack cycle
    logic        ack;
    logic [31:0] rdata;
    logic        err;

    modport requester (
        output req,
        output write,
        output addr,
        output wdata,
        output wstrb,
        output size,
        input  ack,
        input  rdata,
        input  err
    );

    modport responder (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        input  wstrb,
        input  size,
        output ack,
        output rdata,
        output err
    );

endinterface

//--- source/lsu_core.sv
module lsu_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req,
    input  logic           wen,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    output logic           err,
    output logic           busy,
    mem_bus_if.requester   bus
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    state_t      state;
    logic        accept;

    // request held until ack
    logic        lat_write;
    logic        lat_sign;
    size_t       lat_size;
    logic [31:0] lat_addr;
    logic [31:0] lat_wdata;
    logic [3:0]  lat_wstrb;

    logic [4:0]  wr_shamt;
    logic [3:0]  strb_next;
    logic [4:0]  rd_shamt;
    logic [31:0] rd_shift;

    assign accept = (state == S_IDLE) && req;

    // lane offset in bits
    assign wr_shamt = {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: strb_next = 4'b0001 << addr[1:0];
            SIZE_HALF: strb_next = addr[1] ? 4'b1100 : 4'b0011;
            default:   strb_next = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (req) state <= S_ISSUE;
                S_ISSUE: state <= S_WAIT;
                S_WAIT:  if (bus.ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_write <= wen;
            lat_sign  <= sign;
            lat_size  <= size;
            lat_addr  <= addr;
            lat_wdata <= wdata << wr_shamt;
            lat_wstrb <= strb_next;
        end
    end

    assign bus.req   = (state == S_ISSUE);
    assign bus.write = lat_write;
    assign bus.addr  = lat_addr;
    assign bus.wdata = lat_wdata;
    assign bus.wstrb = lat_wstrb;
    assign bus.size  = lat_size;

    // bring the addressed lanes back down to bit 0
    assign rd_shamt = {lat_addr[1:0], 3'b000};
    assign rd_shift = bus.rdata >> rd_shamt;

    always_comb begin
        case (lat_size)
            SIZE_BYTE: rdata = {{24{rd_shift[7] & lat_sign}}, rd_shift[7:0]};
            SIZE_HALF: rdata = {{16{rd_shift[15] & lat_sign}}, rd_shift[15:0]};
            default:   rdata = rd_shift;
        endcase
    end

    assign done = (state == S_WAIT) && bus.ack;
    assign err  = done && bus.err;
    assign busy = (state != S_IDLE);

endmodule

//--- source/addr_router.sv
module addr_router (
    mem_bus_if.responder core,
    mem_bus_if.requester clint,
    mem_bus_if.requester axi
);
    import lsu_pkg::*;

    logic is_clint;

    // address stays stable until ack, so the select does too
    assign is_clint = (core.addr >= CLINT_BASE) && (core.addr <= CLINT_LAST);

    // timer side
    assign clint.req   = is_clint && core.req;
    assign clint.write = is_clint ? core.write : 1'b0;
    assign clint.addr  = is_clint ? core.addr  : 32'd0;
    assign clint.wdata = is_clint ? core.wdata : 32'd0;
    assign clint.wstrb = is_clint ? core.wstrb : 4'd0;
    assign clint.size  = is_clint ? core.size  : SIZE_BYTE;

    // external bus side
    assign axi.req   = !is_clint && core.req;
    assign axi.write = is_clint ? 1'b0      : core.write;
    assign axi.addr  = is_clint ? 32'd0     : core.addr;
    assign axi.wdata = is_clint ? 32'd0     : core.wdata;
    assign axi.wstrb = is_clint ? 4'd0      : core.wstrb;
    assign axi.size  = is_clint ? SIZE_BYTE : core.size;

    // reply from whichever side owns the access
    assign core.ack   = is_clint ? clint.ack   : axi.ack;
    assign core.rdata = is_clint ? clint.rdata : axi.rdata;
    assign core.err   = is_clint ? clint.err   : axi.err;

endmodule

//--- source/clint_timer.sv
module clint_timer (
    input  logic         clk,
    input  logic         rst_n,
    mem_bus_if.responder bus
);

    logic [63:0] mtime;
    logic        ack_q;
    logic        err_q;
    logic [31:0] rdata_q;

    // free-running, wraps at 2^64
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // one-cycle reply, writes are refused with err
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= bus.req;
            err_q <= bus.req && bus.write;
        end
    end

    // bit 2 picks the high word
    always_ff @(posedge clk) begin
        if (bus.req) begin
            rdata_q <= bus.addr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.rdata = rdata_q;

endmodule

//--- source/axi_master.sv
module axi_master (
    input  logic         clk,
    input  logic         rst_n,
    mem_bus_if.responder bus,

    input  logic         axi_awready,
    output logic         axi_awvalid,
    output logic [31:0]  axi_awaddr,
    output logic [3:0]   axi_awid,
    output logic [7:0]   axi_awlen,
    output logic [2:0]   axi_awsize,
    output logic [1:0]   axi_awburst,

    input  logic         axi_wready,
    output logic         axi_wvalid,
    output logic [31:0]  axi_wdata,
    output logic [3:0]   axi_wstrb,
    output logic         axi_wlast,

    output logic         axi_bready,
    input  logic         axi_bvalid,
    input  logic [1:0]   axi_bresp,
    input  logic [3:0]   axi_bid,

    input  logic         axi_arready,
    output logic         axi_arvalid,
    output logic [31:0]  axi_araddr,
    output logic [3:0]   axi_arid,
    output logic [7:0]   axi_arlen,
    output logic [2:0]   axi_arsize,
    output logic [1:0]   axi_arburst,

    output logic         axi_rready,
    input  logic         axi_rvalid,
    input  logic [1:0]   axi_rresp,
    input  logic [31:0]  axi_rdata,
    input  logic         axi_rlast,
    input  logic [3:0]   axi_rid
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_t;

    state_t      state;
    logic        aw_done;
    logic        w_done;
    logic        ack_q;
    logic        err_q;
    logic        b_err;
    logic        r_err;
    logic [31:0] rdata_q;

    // each channel finishes on its own handshake or is already done
    assign aw_done = !axi_awvalid || axi_awready;
    assign w_done  = !axi_wvalid || axi_wready;

    // a wrong id or a missing last also counts as a failed beat
    assign b_err = (axi_bresp != RESP_OKAY) || (axi_bid != AXI_ID);
    assign r_err = (axi_rresp != RESP_OKAY) || (axi_rid != AXI_ID) || !axi_rlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            axi_arvalid <= 1'b0;
            axi_bready  <= 1'b0;
            axi_rready  <= 1'b0;
            ack_q       <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    err_q <= 1'b0;
                    if (bus.req) begin
                        state       <= ST_ADDR;
                        axi_awvalid <= bus.write;
                        axi_wvalid  <= bus.write;
                        axi_arvalid <= !bus.write;
                    end
                end
                ST_ADDR: begin
                    if (bus.write) begin
                        if (axi_awready) axi_awvalid <= 1'b0;
                        if (axi_wready) axi_wvalid <= 1'b0;
                        if (aw_done && w_done) begin
                            state      <= ST_RESP;
                            axi_bready <= 1'b1;
                        end
                    end else if (axi_arready) begin
                        axi_arvalid <= 1'b0;
                        axi_rready  <= 1'b1;
                        state       <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (axi_bready && axi_bvalid) begin
                        axi_bready <= 1'b0;
                        ack_q      <= 1'b1;
                        err_q      <= b_err;
                        state      <= ST_IDLE;
                    end
                    if (axi_rready && axi_rvalid) begin
                        axi_rready <= 1'b0;
                        ack_q      <= 1'b1;
                        err_q      <= r_err;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (axi_rready && axi_rvalid) begin
            rdata_q <= axi_rdata;
        end
    end

    // request fields are held by the requester until ack
    assign axi_awaddr  = bus.addr;
    assign axi_awid    = AXI_ID;
    assign axi_awlen   = AXI_LEN_SINGLE;
    assign axi_awsize  = {1'b0, bus.size};
    assign axi_awburst = AXI_BURST_INCR;

    assign axi_wdata = bus.wdata;
    assign axi_wstrb = bus.wstrb;
    assign axi_wlast = 1'b1;

    assign axi_araddr  = bus.addr;
    assign axi_arid    = AXI_ID;
    assign axi_arlen   = AXI_LEN_SINGLE;
    assign axi_arsize  = {1'b0, bus.size};
    assign axi_arburst = AXI_BURST_INCR;

    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.rdata = rdata_q;

endmodule

//--- source/lsu_top.sv
module lsu_top (
    input  logic           clk,
    input  logic           rst_n,

    // pipeline side
    input  logic           req,
    input  logic           wen,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    output logic           err,
    output logic           busy,

    // external AXI4 master
    input  logic           axi_awready,
    output logic           axi_awvalid,
    output logic [31:0]    axi_awaddr,
    output logic [3:0]     axi_awid,
    output logic [7:0]     axi_awlen,
    output logic [2:0]     axi_awsize,
    output logic [1:0]     axi_awburst,
    input  logic           axi_wready,
    output logic           axi_wvalid,
    output logic [31:0]    axi_wdata,
    output logic [3:0]     axi_wstrb,
    output logic           axi_wlast,
    output logic           axi_bready,
    input  logic           axi_bvalid,
    input  logic [1:0]     axi_bresp,
    input  logic [3:0]     axi_bid,
    input  logic           axi_arready,
    output logic           axi_arvalid,
    output logic [31:0]    axi_araddr,
    output logic [3:0]     axi_arid,
    output logic [7:0]     axi_arlen,
    output logic [2:0]     axi_arsize,
    output logic [1:0]     axi_arburst,
    output logic           axi_rready,
    input  logic           axi_rvalid,
    input  logic [1:0]     axi_rresp,
    input  logic [31:0]    axi_rdata,
    input  logic           axi_rlast,
    input  logic [3:0]     axi_rid
);

    mem_bus_if core_bus ();
    mem_bus_if clint_bus ();
    mem_bus_if axi_bus ();

    lsu_core lsu_core_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .busy  (busy),
        .bus   (core_bus.requester)
    );

    addr_router addr_router_inst (
        .core  (core_bus.responder),
        .clint (clint_bus.requester),
        .axi   (axi_bus.requester)
    );

    clint_timer clint_timer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (clint_bus.responder)
    );

    axi_master axi_master_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (axi_bus.responder),
        .axi_awready (axi_awready),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awid    (axi_awid),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_wready  (axi_wready),
        .axi_wvalid  (axi_wvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_bready  (axi_bready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .axi_bid     (axi_bid),
        .axi_arready (axi_arready),
        .axi_arvalid (axi_arvalid),
        .axi_araddr  (axi_araddr),
        .axi_arid    (axi_arid),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_rready  (axi_rready),
        .axi_rvalid  (axi_rvalid),
        .axi_rresp   (axi_rresp),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .axi_rid     (axi_rid)
    );

endmodule

//--- testbench/axi_mem_model.sv
module axi_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        axi_awvalid,
    output logic        axi_awready,
    input  logic [31:0] axi_awaddr,
    input  logic        axi_wvalid,
    output logic        axi_wready,
    input  logic [31:0] axi_wdata,
    input  logic [3:0]  axi_wstrb,
    output logic        axi_bvalid,
    input  logic        axi_bready,
    output logic [1:0]  axi_bresp,
    output logic [3:0]  axi_bid,
    input  logic        axi_arvalid,
    output logic        axi_arready,
    input  logic [31:0] axi_araddr,
    output logic        axi_rvalid,
    input  logic        axi_rready,
    output logic [31:0] axi_rdata,
    output logic [1:0]  axi_rresp,
    output logic        axi_rlast,
    output logic [3:0]  axi_rid
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam logic [31:0] MEM_BASE = 32'h8000_0000;
    localparam logic [31:0] FILL_XOR = 32'h6c3a_91e5;

    // 64 words at MEM_BASE, indexed by addr[7:2]
    logic [31:0] mem [0:63];
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        aw_got;
    logic        w_got;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  ar_wait;
    integer      seed;

    function automatic logic in_err_region(logic [31:0] a);
        return (a >= 32'h3000_0000) && (a < MEM_BASE);
    endfunction

    initial begin
        logic [6:0] i;
        seed = 79649;
        for (i = 7'd0; i < 7'd64; i = i + 7'd1) begin
            mem[i[5:0]] = (MEM_BASE + {23'd0, i, 2'b00}) ^ FILL_XOR;
        end
    end

    assign axi_bid   = AXI_ID;
    assign axi_rid   = AXI_ID;
    assign axi_rlast = 1'b1;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            axi_bvalid  <= 1'b0;
            axi_bresp   <= RESP_OKAY;
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
            axi_rresp   <= RESP_OKAY;
            axi_rdata   <= 32'd0;
            aw_got      <= 1'b0;
            w_got       <= 1'b0;
            aw_wait     <= 2'd0;
            w_wait      <= 2'd0;
            ar_wait     <= 2'd0;
        end else begin
            // write address, ready after 0 to 3 cycles
            if (axi_awvalid && !axi_awready && !aw_got) begin
                if (aw_wait == 2'd0) axi_awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (axi_awvalid && axi_awready) begin
                axi_awready <= 1'b0;
                aw_got      <= 1'b1;
                aw_addr     <= axi_awaddr;
                aw_wait     <= 2'($random(seed));
            end
            // write data
            if (axi_wvalid && !axi_wready && !w_got) begin
                if (w_wait == 2'd0) axi_wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            if (axi_wvalid && axi_wready) begin
                axi_wready <= 1'b0;
                w_got      <= 1'b1;
                w_data     <= axi_wdata;
                w_strb     <= axi_wstrb;
                w_wait     <= 2'($random(seed));
            end
            // both halves in, commit and respond
            if (aw_got && w_got && !axi_bvalid) begin
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
                axi_bvalid <= 1'b1;
                axi_bresp  <= in_err_region(aw_addr) ? RESP_SLVERR : RESP_OKAY;
                if (!in_err_region(aw_addr)) begin
                    if (w_strb[0]) mem[aw_addr[7:2]][7:0] <= w_data[7:0];
                    if (w_strb[1]) mem[aw_addr[7:2]][15:8] <= w_data[15:8];
                    if (w_strb[2]) mem[aw_addr[7:2]][23:16] <= w_data[23:16];
                    if (w_strb[3]) mem[aw_addr[7:2]][31:24] <= w_data[31:24];
                end
            end
            if (axi_bvalid && axi_bready) axi_bvalid <= 1'b0;
            // read address, data follows in the next cycle
            if (axi_arvalid && !axi_arready && !axi_rvalid) begin
                if (ar_wait == 2'd0) axi_arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (axi_arvalid && axi_arready) begin
                axi_arready <= 1'b0;
                ar_wait     <= 2'($random(seed));
                axi_rvalid  <= 1'b1;
                axi_rdata   <= mem[axi_araddr[7:2]];
                axi_rresp   <= in_err_region(axi_araddr) ? RESP_SLVERR : RESP_OKAY;
            end
            if (axi_rvalid && axi_rready) axi_rvalid <= 1'b0;
        end
    end

endmodule

//--- testbench/lsu_asserts.sv
module lsu_asserts (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic axi_awvalid,
    input logic axi_awready,
    input logic axi_wvalid,
    input logic axi_arvalid,
    input logic axi_arready
);
    timeunit 1ns;
    timeprecision 100ps;

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    awvalid_holds: assert property (@(posedge clk) disable iff (!rst_n)
        axi_awvalid && !axi_awready |=> axi_awvalid)
        else $error("axi_awvalid dropped before axi_awready");

    arvalid_holds: assert property (@(posedge clk) disable iff (!rst_n)
        axi_arvalid && !axi_arready |=> axi_arvalid)
        else $error("axi_arvalid dropped before axi_arready");

    // no valid on the bus while held in reset
    valids_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(axi_awvalid || axi_wvalid || axi_arvalid))
        else $error("AXI valid high during reset");

endmodule

bind lsu_top lsu_asserts lsu_asserts_inst (.*);

//--- testbench/lsu_tb.sv
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int          NUM_OPS    = 400;
    localparam int          MAX_CYCLES = 10000;
    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
    localparam logic [31:0] FILL_XOR   = 32'h6c3a_91e5;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        wen;
    logic        sign;
    size_t       size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        err;
    logic        busy;

    // AXI wires between the DUT and the slave model
    logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_wlast;
    logic        axi_bvalid, axi_bready, axi_arvalid, axi_arready;
    logic        axi_rvalid, axi_rready, axi_rlast;
    logic [31:0] axi_awaddr, axi_wdata, axi_araddr, axi_rdata;
    logic [7:0]  axi_awlen, axi_arlen;
    logic [3:0]  axi_awid, axi_arid, axi_bid, axi_rid, axi_wstrb;
    logic [2:0]  axi_awsize, axi_arsize;
    logic [1:0]  axi_awburst, axi_arburst, axi_bresp, axi_rresp;

    // byte image of the memory window
    logic [7:0]  model [0:255];
    integer      seed;
    int          cycles = 0;
    int          errors = 0;
    int          done_count = 0;

    lsu_top lsu_top_inst (.*);
    axi_mem_model axi_mem_model_inst (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (done) done_count <= done_count + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("error: done never arrived, run stopped after %0d cycles", cycles);
            $display("errors: %0d, done pulses: %0d", errors, done_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("error: %s = %h, expected %h, addr %h", name, got, want, addr);
        end
    endtask

    function automatic logic [31:0] predict_load(logic [7:0] off, size_t sz, logic sgn);
        logic [15:0] half;
        logic [7:0]  b;
        b    = model[off];
        half = {model[off | 8'd1], model[off]};
        case (sz)
            SIZE_BYTE: return sgn ? {{24{b[7]}}, b} : {24'd0, b};
            SIZE_HALF: return sgn ? {{16{half[15]}}, half} : {16'd0, half};
            default:   return {model[off | 8'd3], model[off | 8'd2], half};
        endcase
    endfunction

    task automatic store_model(input logic [7:0] off, input size_t sz, input logic [31:0] d);
        model[off] = d[7:0];
        if (sz != SIZE_BYTE) model[off | 8'd1] = d[15:8];
        if (sz == SIZE_WORD) begin
            model[off | 8'd2] = d[23:16];
            model[off | 8'd3] = d[31:24];
        end
    endtask

    // byte lanes covered by an access of size sz starting at lane
    function automatic logic [3:0] lane_mask(logic [1:0] lane, size_t sz);
        logic [3:0] m;
        int         nb;
        int         i;
        nb = (sz == SIZE_BYTE) ? 1 : ((sz == SIZE_HALF) ? 2 : 4);
        for (i = 0; i < 4; i++) begin
            m[i] = (i >= int'(lane)) && (i < int'(lane) + nb);
        end
        return m;
    endfunction

    // single-beat AXI fields for the access in flight
    task automatic check_axi_request(input size_t sz, input logic [31:0] a);
        logic [31:0] want_size;
        // AxSIZE is log2 of the byte count
        want_size = (sz == SIZE_BYTE) ? 32'd0 : ((sz == SIZE_HALF) ? 32'd1 : 32'd2);
        if (axi_awvalid) begin
            expect_equal("axi_awaddr", axi_awaddr, a);
            expect_equal("axi_awsize", {29'd0, axi_awsize}, want_size);
            expect_equal("axi_awlen", {24'd0, axi_awlen}, 32'd0);
            expect_equal("axi_awburst", {30'd0, axi_awburst}, 32'd1);
            expect_equal("axi_awid", {28'd0, axi_awid}, 32'd0);
        end
        if (axi_wvalid) begin
            expect_equal("axi_wstrb", {28'd0, axi_wstrb}, {28'd0, lane_mask(a[1:0], sz)});
            expect_equal("axi_wlast", {31'd0, axi_wlast}, 32'd1);
        end
        if (axi_arvalid) begin
            expect_equal("axi_araddr", axi_araddr, a);
            expect_equal("axi_arsize", {29'd0, axi_arsize}, want_size);
            expect_equal("axi_arlen", {24'd0, axi_arlen}, 32'd0);
            expect_equal("axi_arburst", {30'd0, axi_arburst}, 32'd1);
            expect_equal("axi_arid", {28'd0, axi_arid}, 32'd0);
        end
    endtask

    // one request on the falling edge, then wait for done
    task automatic run_op(input logic w, input logic s, input size_t sz,
                          input logic [31:0] a, input logic [31:0] d,
                          output logic [31:0] rd, output logic e,
                          output int lat, output logic axi_seen);
        while (busy) @(negedge clk);
        req      = 1'b1;
        wen      = w;
        sign     = s;
        size     = sz;
        addr     = a;
        wdata    = d;
        lat      = 0;
        axi_seen = 1'b0;
        do begin
            @(negedge clk);
            req = 1'b0;
            lat = lat + 1;
            if (axi_awvalid || axi_wvalid || axi_arvalid) axi_seen = 1'b1;
            check_axi_request(sz, a);
            if (!done) expect_equal("busy", {31'd0, busy}, 32'd1);
        end while (!done);
        rd = rdata;
        e  = err;
    endtask

    initial begin
        logic [8:0]  k;
        logic [31:0] word;
        logic [31:0] rnd;
        logic [31:0] wd;
        logic [31:0] a;
        logic [31:0] got;
        logic [31:0] prev_low;
        logic [7:0]  off;
        logic [3:0]  kind;
        size_t       sz;
        logic        wr;
        logic        sgn;
        logic        e;
        logic        axi_seen;
        logic        have_prev;
        int          lat;
        int          prev_cyc;
        int          n;

        seed      = 79649;
        req       = 1'b0;
        wen       = 1'b0;
        sign      = 1'b0;
        size      = SIZE_BYTE;
        addr      = 32'd0;
        wdata     = 32'd0;
        rst_n     = 1'b0;
        have_prev = 1'b0;
        prev_low  = 32'd0;
        prev_cyc  = 0;
        for (k = 9'd0; k < 9'd256; k = k + 9'd1) begin
            word = ((MEM_BASE + {24'd0, k[7:2], 2'b00}) ^ FILL_XOR) >> {k[1:0], 3'b000};
            model[k[7:0]] = word[7:0];
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (n = 0; n < NUM_OPS; n++) begin
            rnd  = $random(seed);
            wd   = $random(seed);
            wr   = rnd[2];
            sgn  = rnd[3];
            kind = rnd[7:4];
            sz   = (rnd[1:0] == 2'd3) ? SIZE_WORD : size_t'(rnd[1:0]);
            off  = rnd[15:8];
            if (sz == SIZE_HALF) off[0] = 1'b0;
            if (sz == SIZE_WORD) off[1:0] = 2'b00;
            if (kind < 4'd10) begin
                a = MEM_BASE | {24'd0, off};
                run_op(wr, sgn, sz, a, wd, got, e, lat, axi_seen);
                expect_equal("err", {31'd0, e}, 32'd0);
                if (wr) begin
                    store_model(off, sz, wd);
                end else begin
                    expect_equal("rdata", got, predict_load(off, sz, sgn));
                end
            end else if (kind < 4'd12) begin
                // low byte aliases the memory window, so a stray write shows up later
                a = {4'h3, rnd[31:16], 4'h0, off};
                run_op(wr, sgn, sz, a, wd, got, e, lat, axi_seen);
                expect_equal("err", {31'd0, e}, 32'd1);
            end else begin
                a = rnd[16] ? CLINT_BASE + 32'd4 : CLINT_BASE;
                run_op(wr, 1'b0, SIZE_WORD, a, wd, got, e, lat, axi_seen);
                expect_equal("done latency", lat, 2);
                expect_equal("err", {31'd0, e}, {31'd0, wr});
                if (axi_seen) begin
                    errors++;
                    $display("error: AXI valid raised during a timer access at %h", a);
                end
                if (!wr && a[2]) begin
                    expect_equal("rdata", got, 32'd0);
                end else if (!wr) begin
                    // mtime moves once per cycle between the two done pulses
                    if (have_prev && (got - prev_low < 32'(cycles - prev_cyc))) begin
                        errors++;
                        $display("error: rdata = %h after %h, step below %0d cycles",
                                 got, prev_low, cycles - prev_cyc);
                    end
                    have_prev = 1'b1;
                    prev_low  = got;
                    prev_cyc  = cycles;
                end
            end
        end

        @(negedge clk);
        expect_equal("done count", done_count, NUM_OPS);
        $display("errors: %0d, operations: %0d, done pulses: %0d", errors, NUM_OPS, done_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/lsu_pkg.sv
source/mem_bus_if.sv
source/lsu_core.sv
source/addr_router.sv
source/clint_timer.sv
source/axi_master.sv
source/lsu_top.sv
testbench/axi_mem_model.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module lsu_tb \
    -f verilog.f -o lsu_tb_sim || exit 1
./obj_dir/lsu_tb_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST PASS$" sim.log && echo "simulation passed" || exit 1
